// File: eye_tracker.f
eye_tracker_video_pkg.sv
eye_tracker_link_pkg.sv
cl_input_align.sv
centroid_lane.sv
centroid_report.sv
uart_tx.sv
eye_tracker_top.sv
eye_tracker_assertions.sv
tb_eye_tracker.sv

// File: Makefile
TOOL     ?= verilator
TOP      ?= tb_eye_tracker
FILELIST ?= eye_tracker.f
FLAGS    ?= --timing --assert
BUILD    ?= obj_dir
LOG      ?= sim.log

.PHONY: lint sim clean

lint:
	$(TOOL) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "Testbench passed" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// File: tb_eye_tracker.sv
`timescale 1ns/1ps
`default_nettype none

module tb_eye_tracker;
    import eye_tracker_video_pkg::*;
    import eye_tracker_link_pkg::*;

    localparam int     CLK_HALF       = 4;
    localparam int     RESET_CYCLES   = 10;
    localparam int     MAX_W          = 16;
    localparam int     MAX_H          = 12;
    localparam int     LINE_GAP       = 4;
    localparam int     IDLE_CYCLES    = 200;
    localparam int     SETTLE_CYCLES  = 2 * BIT_CYCLES;
    localparam int     QUIET_CYCLES   = 2 * 10 * BIT_CYCLES + 40;
    localparam pixel_t EDGE_THRESHOLD = 8'd80;
    // Worst case frame has a stall before every beat
    localparam int     FRAME_CYCLES   = MAX_H * (MAX_W + LINE_GAP) + 4;
    localparam int     REPORT_CYCLES  = REPORT_BYTES * 10 * BIT_CYCLES;
    localparam int     NUM_FRAMES     = 7;
    localparam int     NUM_REPORTS    = 6;
    localparam int     WATCHDOG_CYCLES = 2 * (RESET_CYCLES + IDLE_CYCLES + QUIET_CYCLES
        + NUM_FRAMES * FRAME_CYCLES + NUM_REPORTS * (REPORT_CYCLES + SETTLE_CYCLES));

    // Expected report fields in their zero-extended widths
    typedef struct packed {
        logic [23:0] s;
        logic [31:0] sx;
        logic [31:0] sy;
    } report_sums_t;

    logic       cclk = 1'b0;
    logic       rst_n;
    logic       fval;
    logic       lval;
    logic       dval;
    pixel_t     data_l;
    pixel_t     data_r;
    pixel_t     threshold;
    logic       uart_txd;
    uart_byte_t rx_q [$];
    pixel_t     img_a [MAX_H][MAX_W];
    pixel_t     img_b [MAX_H][MAX_W];
    pixel_t     img_c [MAX_H][MAX_W];

    always #CLK_HALF cclk = ~cclk;

    eye_tracker_top eye_tracker_top_i (
        .cclk      (cclk),
        .rst_n     (rst_n),
        .fval      (fval),
        .lval      (lval),
        .dval      (dval),
        .data_l    (data_l),
        .data_r    (data_r),
        .threshold (threshold),
        .uart_txd  (uart_txd)
    );

    task automatic check_equal(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("FAILED %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
            $display("Testbench failed");
            $fatal(1, "Stopping at first mismatch");
        end
    endtask

    // ----------------------------------------------------------------------
    // Reference model and stimulus
    // ----------------------------------------------------------------------
    function automatic report_sums_t pupil_model(input pixel_t img [MAX_H][MAX_W],
                                                 input int w, input int h, input pixel_t thr);
        report_sums_t r;
        r = '0;
        for (int y = 0; y < h; y++) begin
            for (int x = 0; x < w; x++) begin
                // Pupil means strictly below threshold
                if (img[y][x] < thr) begin
                    r.s  = r.s + 24'd1;
                    r.sx = r.sx + 32'(x);
                    r.sy = r.sy + 32'(y);
                end
            end
        end
        return r;
    endfunction

    task automatic set_threshold(input pixel_t thr);
        @(posedge cclk);
        threshold <= thr;
    endtask

    task automatic drive_frame(input pixel_t img [MAX_H][MAX_W], input int w, input int h,
                               input bit stalls);
        @(posedge cclk);
        fval <= 1'b1;
        for (int y = 0; y < h; y++) begin
            for (int bx = 0; bx < w / NUM_TAPS; bx++) begin
                // Stall beat with dark pixels
                if (stalls && $urandom_range(0, 3) == 0) begin
                    lval   <= 1'b1;
                    dval   <= 1'b0;
                    data_l <= 8'd0;
                    data_r <= 8'd0;
                    @(posedge cclk);
                end
                lval   <= 1'b1;
                dval   <= 1'b1;
                data_l <= img[y][NUM_TAPS * bx];
                data_r <= img[y][NUM_TAPS * bx + 1];
                @(posedge cclk);
            end
            // Line blanking carries dark data too
            lval   <= 1'b0;
            dval   <= stalls;
            data_l <= 8'd0;
            data_r <= 8'd0;
            repeat (LINE_GAP) @(posedge cclk);
        end
        fval <= 1'b0;
        dval <= 1'b0;
        @(posedge cclk);
    endtask

    task automatic fill_dark_square();
        for (int y = 0; y < MAX_H; y++) begin
            for (int x = 0; x < MAX_W; x++) begin
                img_a[y][x] = (x >= 5 && x <= 10 && y >= 3 && y <= 8) ? 8'd20 : 8'd200;
            end
        end
    endtask

    // ----------------------------------------------------------------------
    // UART side
    // ----------------------------------------------------------------------
    task automatic decode_byte(output uart_byte_t b);
        do @(negedge cclk); while (uart_txd !== 1'b0);
        // Move to the middle of the start bit
        repeat (BIT_CYCLES / 2) @(negedge cclk);
        check_equal("uart start bit", 32'd0, 32'(uart_txd));
        for (int i = 0; i < 8; i++) begin
            repeat (BIT_CYCLES) @(negedge cclk);
            b[i] = uart_txd;
        end
        repeat (BIT_CYCLES) @(negedge cclk);
        check_equal("uart stop bit", 32'd1, 32'(uart_txd));
    endtask

    initial begin : uart_monitor
        uart_byte_t rx_byte;
        @(posedge rst_n);
        forever begin
            decode_byte(rx_byte);
            rx_q.push_back(rx_byte);
        end
    end

    task automatic expect_report(input string name, input report_sums_t exp);
        uart_byte_t   b [REPORT_BYTES];
        report_sums_t got;
        while (rx_q.size() < REPORT_BYTES) begin
            @(posedge cclk);
        end
        for (int i = 0; i < REPORT_BYTES; i++) begin
            b[i] = rx_q.pop_front();
        end
        got.s  = {b[1], b[2], b[3]};
        got.sx = {b[4], b[5], b[6], b[7]};
        got.sy = {b[8], b[9], b[10], b[11]};
        check_equal({name, " sync"}, 32'(REPORT_SYNC), 32'(b[0]));
        check_equal({name, " s"}, 32'(exp.s), 32'(got.s));
        check_equal({name, " sx"}, exp.sx, got.sx);
        check_equal({name, " sy"}, exp.sy, got.sy);
        repeat (SETTLE_CYCLES) @(posedge cclk);
    endtask

    // ----------------------------------------------------------------------
    // Directed tests
    // ----------------------------------------------------------------------
    task automatic idle_after_reset();
        repeat (IDLE_CYCLES) begin
            @(negedge cclk);
            check_equal("idle uart_txd", 32'd1, 32'(uart_txd));
        end
    endtask

    task automatic dark_square();
        fill_dark_square();
        set_threshold(8'd100);
        drive_frame(img_a, MAX_W, MAX_H, 1'b0);
        expect_report("dark square", pupil_model(img_a, MAX_W, MAX_H, 8'd100));
    endtask

    task automatic threshold_edge();
        // Mix of equal, one below and one above on both column parities
        for (int y = 0; y < 4; y++) begin
            for (int x = 0; x < 8; x++) begin
                case ((x + y) % 3)
                    0:       img_c[y][x] = EDGE_THRESHOLD;
                    1:       img_c[y][x] = EDGE_THRESHOLD - 8'd1;
                    default: img_c[y][x] = EDGE_THRESHOLD + 8'd1;
                endcase
            end
        end
        set_threshold(EDGE_THRESHOLD);
        drive_frame(img_c, 8, 4, 1'b0);
        expect_report("threshold edge", pupil_model(img_c, 8, 4, EDGE_THRESHOLD));
    endtask

    task automatic gaps_ignored();
        fill_dark_square();
        set_threshold(8'd100);
        drive_frame(img_a, MAX_W, MAX_H, 1'b1);
        expect_report("gaps ignored", pupil_model(img_a, MAX_W, MAX_H, 8'd100));
    endtask

    task automatic back_to_back_frames();
        report_sums_t first_exp;
        report_sums_t third_exp;
        fill_dark_square();
        for (int y = 0; y < MAX_H; y++) begin
            for (int x = 0; x < MAX_W; x++) begin
                img_b[y][x] = 8'd5;
                img_c[y][x] = ((x * 3 + y * 5) % 7 == 0) ? 8'd10 : 8'd150;
            end
        end
        first_exp = pupil_model(img_a, MAX_W, MAX_H, 8'd100);
        third_exp = pupil_model(img_c, 8, 6, 8'd100);
        set_threshold(8'd100);
        drive_frame(img_a, MAX_W, MAX_H, 1'b0);
        // Short dark frame ends while the first report is on the line
        drive_frame(img_b, 4, 2, 1'b0);
        expect_report("back-to-back first", first_exp);
        repeat (QUIET_CYCLES) @(posedge cclk);
        check_equal("back-to-back dropped frame bytes", 32'd0, 32'(rx_q.size()));
        drive_frame(img_c, 8, 6, 1'b0);
        expect_report("back-to-back third", third_exp);
    endtask

    task automatic random_frame();
        pixel_t thr;
        thr = pixel_t'($urandom_range(1, 255));
        for (int y = 0; y < MAX_H; y++) begin
            for (int x = 0; x < MAX_W; x++) begin
                img_a[y][x] = pixel_t'($urandom_range(0, 255));
            end
        end
        set_threshold(thr);
        drive_frame(img_a, MAX_W, MAX_H, 1'b0);
        expect_report("random frame", pupil_model(img_a, MAX_W, MAX_H, thr));
    endtask

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge cclk);
        $display("Timeout: tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Testbench failed");
        $fatal(1, "Watchdog expired");
    end

    initial begin : main_sequence
        logic assert_fail;
        void'($urandom(32'hc853));
        rst_n     <= 1'b0;
        fval      <= 1'b0;
        lval      <= 1'b0;
        dval      <= 1'b0;
        data_l    <= 8'd0;
        data_r    <= 8'd0;
        threshold <= 8'd100;
        repeat (RESET_CYCLES) @(posedge cclk);
        rst_n <= 1'b1;
        @(posedge cclk);

        idle_after_reset();
        dark_square();
        threshold_edge();
        gaps_ignored();
        back_to_back_frames();
        random_frame();

        assert_fail = eye_tracker_top_i.u_uart.u_assertions.txd_fail
            | eye_tracker_top_i.u_uart.u_assertions.push_fail
            | eye_tracker_top_i.u_uart.u_assertions.credit_fail;
        if (!assert_fail) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: eye_tracker_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module eye_tracker_assertions (
    input logic                                                  cclk,
    input logic                                                  rst_n,
    input logic                                                  tx_valid,
    input logic                                                  tx_credit,
    input logic                                                  uart_txd,
    input logic [$clog2(eye_tracker_link_pkg::TX_FIFO_DEPTH):0]  fifo_count
);
    import eye_tracker_link_pkg::*;

    typedef logic [$clog2(TX_FIFO_DEPTH):0] count_t;

    logic   txd_fail    = 1'b0;
    logic   push_fail   = 1'b0;
    logic   credit_fail = 1'b0;
    count_t occupancy;

    // Bytes held in the FIFO, counted from pushes and returned credits
    always_ff @(posedge cclk) begin
        if (!rst_n) begin
            occupancy <= '0;
        end else begin
            occupancy <= occupancy + count_t'(tx_valid) - count_t'(tx_credit);
        end
    end

    // Line idles high through reset
    txd_high_in_reset: assert property (@(posedge cclk) !rst_n |=> uart_txd)
        else begin
            txd_fail = 1'b1;
            $error("uart_txd low while reset is asserted");
        end

    // Credits keep the FIFO from overflowing
    no_push_when_full: assert property (@(posedge cclk) disable iff (!rst_n)
        (int'(fifo_count) == TX_FIFO_DEPTH) |-> !tx_valid)
        else begin
            push_fail = 1'b1;
            $error("push into a full TX FIFO");
        end

    credit_needs_data: assert property (@(posedge cclk) disable iff (!rst_n)
        tx_credit |-> (occupancy != '0))
        else begin
            credit_fail = 1'b1;
            $error("tx_credit pulsed with an empty TX FIFO");
        end

endmodule

bind uart_tx eye_tracker_assertions u_assertions (
    .cclk       (cclk),
    .rst_n      (rst_n),
    .tx_valid   (tx_valid),
    .tx_credit  (tx_credit),
    .uart_txd   (uart_txd),
    .fifo_count (fifo_count)
);

`default_nettype wire

// File: eye_tracker_top.sv
`timescale 1ns/1ps
`default_nettype none

module eye_tracker_top (
    input  logic                           cclk,
    input  logic                           rst_n,
    input  logic                           fval,
    input  logic                           lval,
    input  logic                           dval,
    input  eye_tracker_video_pkg::pixel_t  data_l,
    input  eye_tracker_video_pkg::pixel_t  data_r,
    input  eye_tracker_video_pkg::pixel_t  threshold,
    output logic                           uart_txd
);
    import eye_tracker_video_pkg::*;
    import eye_tracker_link_pkg::*;

    cl_beat_t                   beat;
    lane_sums_t [NUM_TAPS-1:0]  lane_sums;
    logic                       tx_valid;
    uart_byte_t                 tx_byte;
    logic                       tx_credit;

    // ------------------------------------------------------------------
    // Video side
    // ------------------------------------------------------------------
    cl_input_align u_align (
        .cclk   (cclk),
        .rst_n  (rst_n),
        .fval   (fval),
        .lval   (lval),
        .dval   (dval),
        .data_l (data_l),
        .data_r (data_r),
        .beat   (beat)
    );

    // One accumulator per camera tap
    for (genvar i = 0; i < NUM_TAPS; i++) begin : g_lane
        centroid_lane #(
            .LANE (i)
        ) u_lane (
            .cclk      (cclk),
            .rst_n     (rst_n),
            .beat      (beat),
            .threshold (threshold),
            .sums      (lane_sums[i])
        );
    end

    // ------------------------------------------------------------------
    // Report and UART
    // ------------------------------------------------------------------
    centroid_report u_report (
        .cclk      (cclk),
        .rst_n     (rst_n),
        .lane_sums (lane_sums),
        .tx_valid  (tx_valid),
        .tx_byte   (tx_byte),
        .tx_credit (tx_credit)
    );

    uart_tx u_uart (
        .cclk      (cclk),
        .rst_n     (rst_n),
        .tx_valid  (tx_valid),
        .tx_byte   (tx_byte),
        .tx_credit (tx_credit),
        .uart_txd  (uart_txd)
    );

endmodule

`default_nettype wire

// File: uart_tx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_tx (
    input  logic                              cclk,
    input  logic                              rst_n,
    input  logic                              tx_valid,
    input  eye_tracker_link_pkg::uart_byte_t  tx_byte,
    output logic                              tx_credit,
    output logic                              uart_txd
);
    import eye_tracker_link_pkg::*;

    uart_byte_t                         fifo_mem [TX_FIFO_DEPTH];
    logic [$clog2(TX_FIFO_DEPTH)-1:0]   wr_ptr;
    logic [$clog2(TX_FIFO_DEPTH)-1:0]   rd_ptr;
    logic [$clog2(TX_FIFO_DEPTH):0]     fifo_count;
    logic                               busy;
    logic [$clog2(BIT_CYCLES)-1:0]      bit_timer;
    logic [3:0]                         bits_left;
    logic [9:0]                         shift_q;
    logic                               bit_tick;
    logic                               frame_done;
    logic                               pop;

    assign bit_tick   = busy && (int'(bit_timer) == BIT_CYCLES - 1);
    assign frame_done = bit_tick && (bits_left == '0);

    // Next byte loads as the stop bit ends, so bytes run back to back
    assign pop        = (fifo_count != '0) && (!busy || frame_done);
    assign tx_credit  = pop;
    assign uart_txd   = shift_q[0];

    // ------------------------------------------------------------------
    // Byte FIFO
    // ------------------------------------------------------------------
    always_ff @(posedge cclk) begin
        if (tx_valid) begin
            fifo_mem[wr_ptr] <= tx_byte;
        end
    end

    always_ff @(posedge cclk) begin
        if (!rst_n) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            fifo_count <= '0;
        end else begin
            if (tx_valid) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({tx_valid, pop})
                2'b10:   fifo_count <= fifo_count + 1'b1;
                2'b01:   fifo_count <= fifo_count - 1'b1;
                default: fifo_count <= fifo_count;
            endcase
        end
    end

    // ------------------------------------------------------------------
    // 8N1 shifter
    // ------------------------------------------------------------------
    always_ff @(posedge cclk) begin
        if (!rst_n) begin
            busy      <= 1'b0;
            bit_timer <= '0;
            bits_left <= '0;
            shift_q   <= '1;
        end else if (pop) begin
            // Stop, data LSB first, start
            busy      <= 1'b1;
            bit_timer <= '0;
            bits_left <= 4'd9;
            shift_q   <= {1'b1, fifo_mem[rd_ptr], 1'b0};
        end else if (frame_done) begin
            busy <= 1'b0;
        end else if (bit_tick) begin
            bit_timer <= '0;
            bits_left <= bits_left - 1'b1;
            shift_q   <= {1'b1, shift_q[9:1]};
        end else if (busy) begin
            bit_timer <= bit_timer + 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: centroid_report.sv
`timescale 1ns/1ps
`default_nettype none

module centroid_report (
    input  logic                                                            cclk,
    input  logic                                                            rst_n,
    input  eye_tracker_video_pkg::lane_sums_t [eye_tracker_video_pkg::NUM_TAPS-1:0] lane_sums,
    output logic                                                            tx_valid,
    output eye_tracker_link_pkg::uart_byte_t                                tx_byte,
    input  logic                                                            tx_credit
);
    import eye_tracker_video_pkg::*;
    import eye_tracker_link_pkg::*;

    typedef logic [$clog2(REPORT_BYTES+1)-1:0] byte_idx_t;

    report_state_e                  state;
    byte_idx_t                      byte_idx;
    credit_t                        credits;
    logic [8*(REPORT_BYTES-1)-1:0]  report_q;
    logic                           all_valid;
    sum_s_t                         tot_s;
    sum_sx_t                        tot_sx;
    sum_sy_t                        tot_sy;
    logic                           start;
    logic                           send_ok;

    // ------------------------------------------------------------------
    // Lane merge
    // ------------------------------------------------------------------
    always_comb begin
        all_valid = 1'b1;
        tot_s     = '0;
        tot_sx    = '0;
        tot_sy    = '0;
        for (int i = 0; i < NUM_TAPS; i++) begin
            all_valid = all_valid & lane_sums[i].valid;
            tot_s     = tot_s + lane_sums[i].s;
            tot_sx    = tot_sx + lane_sums[i].sx;
            tot_sy    = tot_sy + lane_sums[i].sy;
        end
    end

    // Sync byte leaves in the same cycle the totals arrive
    assign start    = (state == IDLE) && all_valid;
    assign send_ok  = (state == SEND) && (credits != '0);
    assign tx_valid = start || send_ok;
    assign tx_byte  = start ? REPORT_SYNC : report_q[$bits(report_q)-1 -: 8];

    // ------------------------------------------------------------------
    // Credits and byte sequencing
    // ------------------------------------------------------------------
    always_ff @(posedge cclk) begin
        if (!rst_n) begin
            credits <= credit_t'(TX_FIFO_DEPTH);
        end else begin
            credits <= credits - credit_t'(tx_valid) + credit_t'(tx_credit);
        end
    end

    always_ff @(posedge cclk) begin
        if (!rst_n) begin
            state    <= IDLE;
            byte_idx <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (start) begin
                        state    <= SEND;
                        byte_idx <= byte_idx_t'(1);
                    end
                end
                SEND: begin
                    if (send_ok) begin
                        byte_idx <= byte_idx + 1'b1;
                        if (byte_idx == byte_idx_t'(REPORT_BYTES - 1)) begin
                            state <= WAIT_CREDIT;
                        end
                    end else begin
                        state <= WAIT_CREDIT;
                    end
                end
                WAIT_CREDIT: begin
                    // After the last byte, stay busy until the FIFO has drained
                    if (byte_idx == byte_idx_t'(REPORT_BYTES)) begin
                        if (credits == credit_t'(TX_FIFO_DEPTH)) begin
                            state    <= IDLE;
                            byte_idx <= '0;
                        end
                    end else if (credits != '0) begin
                        state <= SEND;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // Fields MSB first, zero-extended
    always_ff @(posedge cclk) begin
        if (start) begin
            report_q <= {24'(tot_s), 32'(tot_sx), 32'(tot_sy)};
        end else if (send_ok) begin
            report_q <= report_q << 8;
        end
    end

endmodule

`default_nettype wire

// File: centroid_lane.sv
`timescale 1ns/1ps
`default_nettype none

module centroid_lane #(
    parameter int LANE = 0
) (
    input  logic                               cclk,
    input  logic                               rst_n,
    input  eye_tracker_video_pkg::cl_beat_t    beat,
    input  eye_tracker_video_pkg::pixel_t      threshold,
    output eye_tracker_video_pkg::lane_sums_t  sums
);
    import eye_tracker_video_pkg::*;

    pixel_t  pix;
    coord_t  col;
    logic    hit;
    sum_s_t  s_acc;
    sum_sx_t sx_acc;
    sum_sy_t sy_acc;
    logic    out_valid;
    sum_s_t  out_s;
    sum_sx_t out_sx;
    sum_sy_t out_sy;

    // This tap's pixel and its own column
    assign pix = beat.pix[LANE];
    assign col = beat.x + coord_t'(LANE);
    assign hit = beat.valid && (pix < threshold);

    // Frame accumulators
    always_ff @(posedge cclk) begin
        if (!rst_n || beat.frame_end) begin
            s_acc  <= '0;
            sx_acc <= '0;
            sy_acc <= '0;
        end else if (hit) begin
            s_acc  <= s_acc + 1'b1;
            sx_acc <= sx_acc + sum_sx_t'(col);
            sy_acc <= sy_acc + sum_sy_t'(beat.y);
        end
    end

    always_ff @(posedge cclk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= beat.frame_end;
        end
    end

    // Totals held until the next frame end
    always_ff @(posedge cclk) begin
        if (beat.frame_end) begin
            out_s  <= s_acc;
            out_sx <= sx_acc;
            out_sy <= sy_acc;
        end
    end

    always_comb begin
        sums.valid = out_valid;
        sums.s     = out_s;
        sums.sx    = out_sx;
        sums.sy    = out_sy;
    end

endmodule

`default_nettype wire

// File: cl_input_align.sv
`timescale 1ns/1ps
`default_nettype none

module cl_input_align (
    input  logic                             cclk,
    input  logic                             rst_n,
    input  logic                             fval,
    input  logic                             lval,
    input  logic                             dval,
    input  eye_tracker_video_pkg::pixel_t    data_l,
    input  eye_tracker_video_pkg::pixel_t    data_r,
    output eye_tracker_video_pkg::cl_beat_t  beat
);
    import eye_tracker_video_pkg::*;

    logic                   fval_q;
    logic                   lval_q;
    logic                   active;
    coord_t                 x_cnt;
    coord_t                 y_cnt;
    logic                   valid_q;
    logic                   frame_end_q;
    coord_t                 x_q;
    coord_t                 y_q;
    pixel_t [NUM_TAPS-1:0]  pix_q;

    // Beat carries pixels only inside an active line
    assign active = fval && lval && dval;

    always_ff @(posedge cclk) begin
        if (!rst_n) begin
            fval_q      <= 1'b0;
            lval_q      <= 1'b0;
            valid_q     <= 1'b0;
            frame_end_q <= 1'b0;
        end else begin
            fval_q      <= fval;
            lval_q      <= lval;
            valid_q     <= active;
            frame_end_q <= fval_q && !fval;
        end
    end

    // Column of tap 0, restarts on every line
    always_ff @(posedge cclk) begin
        if (!rst_n || !lval) begin
            x_cnt <= '0;
        end else if (active) begin
            x_cnt <= x_cnt + coord_t'(NUM_TAPS);
        end
    end

    // Row advances at the end of each line within a frame
    always_ff @(posedge cclk) begin
        if (!rst_n || !fval) begin
            y_cnt <= '0;
        end else if (lval_q && !lval) begin
            y_cnt <= y_cnt + 1'b1;
        end
    end

    always_ff @(posedge cclk) begin
        x_q   <= x_cnt;
        y_q   <= y_cnt;
        pix_q <= {data_r, data_l};
    end

    always_comb begin
        beat.valid     = valid_q;
        beat.frame_end = frame_end_q;
        beat.x         = x_q;
        beat.y         = y_q;
        beat.pix       = pix_q;
    end

endmodule

`default_nettype wire

// File: eye_tracker_link_pkg.sv
`default_nettype none

package eye_tracker_link_pkg;

    typedef logic [7:0] uart_byte_t;

    // 8N1 line timing, in cclk cycles per bit
    localparam int BIT_CYCLES = 8;

    // Depth of the TX FIFO, also the starting credit count
    localparam int TX_FIFO_DEPTH = 4;
    typedef logic [2:0] credit_t;

    // Report layout
    localparam int REPORT_BYTES = 12;
    localparam uart_byte_t REPORT_SYNC = 8'hA5;

    typedef enum logic [1:0] {
        IDLE,
        SEND,
        WAIT_CREDIT
    } report_state_e;

endpackage

`default_nettype wire

// File: eye_tracker_video_pkg.sv
`default_nettype none

package eye_tracker_video_pkg;

    // ------------------------------------------------------------------
    // Camera side widths
    // ------------------------------------------------------------------
    localparam int NUM_TAPS = 2;

    typedef logic [7:0]  pixel_t;
    typedef logic [9:0]  coord_t;

    // Centroid sums, sized for a 640x480 sensor
    typedef logic [19:0] sum_s_t;
    typedef logic [27:0] sum_sx_t;
    typedef logic [27:0] sum_sy_t;

    // One registered camera beat, shared by all lanes
    typedef struct packed {
        logic                   valid;
        logic                   frame_end;
        coord_t                 x;
        coord_t                 y;
        pixel_t [NUM_TAPS-1:0]  pix;
    } cl_beat_t;

    // Per-lane frame totals
    typedef struct packed {
        logic    valid;
        sum_s_t  s;
        sum_sx_t sx;
        sum_sy_t sy;
    } lane_sums_t;

endpackage

`default_nettype wire
